//--- Makefile
# Verilator build for the UMI to APB register subsystem
# A failing run ends in $fatal, so the sim target exits nonzero

VERILATOR  ?= verilator
TOP        := umi_apb_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
rtl/umi_apb_pkg.sv
rtl/umi_host_arbiter.sv
rtl/umi2apb.sv
rtl/apb_regfile.sv
rtl/umi_apb_top.sv
test/umi_apb_tb.sv

//--- rtl/apb_regfile.sv
`timescale 1ns/1ps
//##########################################################################
// APB completer with sixteen 64-bit registers
// Even indexes complete in the first access cycle, odd ones wait one more
// Addresses past the last register return a slave error
//##########################################################################

module apb_regfile import umi_apb_pkg::*; (
   input  logic   clk,           // Core clock
   input  logic   nreset,        // Async active low reset
   input  logic   psel,
   input  logic   penable,
   input  logic   pwrite,
   input  paddr_t paddr,
   input  data_t  pwdata,
   input  strb_t  pstrb,         // Byte enables
   output logic   pready,
   output data_t  prdata,
   output logic   pslverr
);

   data_t    regs [REG_COUNT];   // Register storage
   reg_idx_t idx;                // Word index from paddr
   logic     in_range;           // Address hits a register
   logic     access;             // Access phase of a transfer
   logic     wait_cnt;           // Wait state already spent

   //#######################################################################
   // Decode
   //#######################################################################

   assign idx      = paddr[WORD_OFS +: REG_IDX_W];                 // Bits 6:3
   assign in_range = (paddr < paddr_t'(REG_COUNT * STRB_W));
   assign access   = psel & penable;

   //#######################################################################
   // Wait states
   //#######################################################################

   // Odd index needs one extra access cycle
   assign pready = access & (~idx[0] | wait_cnt);

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wait_cnt <= 1'b0;
      end else begin
         wait_cnt <= access & ~pready;             // Clears on completion
      end
   end

   //#######################################################################
   // Read and write
   //#######################################################################

   assign prdata  = in_range ? regs[idx] : '0;     // Zero outside the map
   assign pslverr = pready & ~in_range;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (pready && pwrite && in_range) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (pstrb[b]) begin
               regs[idx][b*8 +: 8] <= pwdata[b*8 +: 8];   // Per byte lane
            end
         end
      end
   end

   //#######################################################################
   // Checks
   //#######################################################################

   // Completion follows a selected cycle at the same address
   a_pready_access : assert property (@(posedge clk) disable iff (!nreset)
      pready |-> $past(psel) && $stable(paddr));

endmodule

//--- rtl/umi2apb.sv
`timescale 1ns/1ps
//##########################################################################
// Bridge from a UMI request port to an APB requester
// One APB transfer per request and at most one request every two cycles
// Reads and writes get a UMI response while posted writes complete silently
//##########################################################################

module umi2apb import umi_apb_pkg::*; (
   input  logic       clk,           // Core clock, also the APB clock
   input  logic       nreset,        // Async active low reset
   // UMI request
   input  umi_pkt_t   req,
   input  logic       req_valid,
   output logic       req_ready,
   // UMI response
   output umi_pkt_t   resp,
   output logic       resp_valid,
   input  logic       resp_ready,
   // APB requester
   output logic       psel,
   output logic       penable,
   output logic       pwrite,        // 1 for write and posted write
   output paddr_t     paddr,
   output data_t      pwdata,
   output strb_t      pstrb,
   output logic [2:0] pprot,
   input  logic       pready,
   input  logic       pslverr,
   input  data_t      prdata
);

   umi_pkt_t   req_r;        // Request held through the access phase
   umi_cmd_t   cmd_cur;      // Command driving APB this cycle
   umi_cmd_t   resp_cmd;     // Response command under construction
   logic       group_match;  // dstaddr is in our group
   logic       live_rw;      // Live opcode maps to an APB transfer
   logic       start;        // Setup phase this cycle
   logic       done;         // Access phase completes this cycle
   logic [1:0] err_r;        // Error code for the response
   data_t      prdata_r;     // Read data for the response

   //#######################################################################
   // Request decode
   //#######################################################################

   generate
      if (GRP_AW != 0) begin : g_grp
         assign group_match = (req.dstaddr[GRP_OFFSET +: GRP_AW] == GRP_ID[GRP_AW-1:0]);
      end else begin : g_nogrp
         assign group_match = 1'b1;       // Group check disabled
      end
   endgenerate

   always_comb begin
      live_rw = 1'b0;
      case (req.cmd.opcode)
         UMI_REQ_READ, UMI_REQ_WRITE, UMI_REQ_POSTED: live_rw = 1'b1;
         UMI_REQ_RDMA, UMI_REQ_ATOMIC:                live_rw = 1'b0;  // Dropped
         default:                                     live_rw = 1'b0;
      endcase
   end

   // Closed during access and while a response waits
   assign req_ready = ~penable & ~resp_valid;

   // Dropped requests still handshake but start no transfer
   assign start = req_valid & req_ready & group_match & live_rw;

   always_ff @(posedge clk) begin
      if (start) begin
         req_r <= req;
      end
   end

   //#######################################################################
   // APB mapping
   //#######################################################################

   assign cmd_cur = start ? req.cmd : req_r.cmd;   // Live in setup and held after

   assign psel    = start | penable;
   assign pwrite  = (cmd_cur.opcode == UMI_REQ_WRITE) | (cmd_cur.opcode == UMI_REQ_POSTED);
   assign paddr   = start ? req.dstaddr[PADDR_W-1:0] : req_r.dstaddr[PADDR_W-1:0];
   assign pwdata  = start ? req.data : req_r.data;
   assign pstrb   = '1;                            // Full word writes only
   assign pprot   = {1'b0, cmd_cur.prot};

   assign done = penable & pready;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         penable <= 1'b0;
      end else if (start) begin
         penable <= 1'b1;                          // Access from next cycle
      end else if (done) begin
         penable <= 1'b0;
      end
   end

   //#######################################################################
   // UMI response
   //#######################################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         resp_valid <= 1'b0;
      end else if (done && req_r.cmd.opcode != UMI_REQ_POSTED) begin
         resp_valid <= 1'b1;
      end else if (resp_ready) begin
         resp_valid <= 1'b0;                       // Handshake taken
      end
   end

   always_ff @(posedge clk) begin
      if (done) begin
         prdata_r <= prdata;
         err_r    <= pslverr ? ERR_SLV : ERR_OK;
      end
   end

   always_comb begin
      resp_cmd        = req_r.cmd;                 // Keep size, len, hostid etc
      resp_cmd.opcode = (req_r.cmd.opcode == UMI_REQ_READ) ? UMI_RESP_READ : UMI_RESP_WRITE;
      resp_cmd.err    = err_r;
      resp.cmd        = resp_cmd;
      resp.dstaddr    = req_r.srcaddr;             // Back to the requester
      resp.srcaddr    = req_r.dstaddr;
      resp.data       = prdata_r;
   end

   //#######################################################################
   // Checks
   //#######################################################################

   // Every setup phase moves on to an access phase
   a_setup_access : assert property (@(posedge clk) disable iff (!nreset)
      psel && !penable |=> psel && penable);

   // Address holds from setup until the completing access cycle
   a_paddr_stable : assert property (@(posedge clk) disable iff (!nreset)
      psel && !done |=> $stable(paddr));

   // Back-pressure keeps the response intact
   a_resp_hold : assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

//--- rtl/umi_apb_pkg.sv
//##########################################################################
// Common types, opcodes and address map of the UMI to APB register block
// Pulled into each RTL module with a wildcard import in the module header
//##########################################################################

package umi_apb_pkg;

   //#######################################################################
   // Widths
   //#######################################################################

   localparam int ADDR_W   = 64;               // UMI address
   localparam int DATA_W   = 64;               // UMI data and APB register
   localparam int PADDR_W  = 16;               // APB address
   localparam int STRB_W   = DATA_W / 8;       // One strobe bit per byte
   localparam int WORD_OFS = $clog2(STRB_W);   // Byte offset bits in paddr

   //#######################################################################
   // Address map and error codes
   //#######################################################################

   localparam int         GRP_OFFSET = 24;       // Group field position in dstaddr
   localparam int         GRP_AW     = 8;        // Group field width, 0 disables
   localparam logic [7:0] GRP_ID     = 8'h5A;    // Group this block answers to
   localparam int         REG_COUNT  = 16;       // Registers in the file
   localparam int         REG_IDX_W  = $clog2(REG_COUNT);

   localparam logic [1:0] ERR_OK  = 2'b00;       // Normal completion
   localparam logic [1:0] ERR_SLV = 2'b10;       // APB slave error

   //#######################################################################
   // Vector types
   //#######################################################################

   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [DATA_W-1:0]    data_t;
   typedef logic [PADDR_W-1:0]   paddr_t;
   typedef logic [STRB_W-1:0]    strb_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   //#######################################################################
   // UMI opcodes in use
   //#######################################################################

   typedef enum logic [4:0] {
      UMI_REQ_READ   = 5'h01,   // Read, returns data
      UMI_RESP_READ  = 5'h02,
      UMI_REQ_WRITE  = 5'h03,   // Acknowledged write
      UMI_RESP_WRITE = 5'h04,
      UMI_REQ_POSTED = 5'h05,   // Write without response
      UMI_REQ_RDMA   = 5'h07,   // Not mapped to APB
      UMI_REQ_ATOMIC = 5'h09    // Not mapped to APB
   } umi_opcode_e;

   // Simplified 32-bit command word, opcode in the top bits
   typedef struct packed {
      logic [4:0] opcode;       // Compared against umi_opcode_e
      logic [2:0] size;
      logic [7:0] len;
      logic [3:0] qos;
      logic [1:0] prot;         // Forwarded to pprot[1:0]
      logic       eom;
      logic       eof;
      logic       ex;
      logic [1:0] user;
      logic [1:0] err;          // ERR_SLV on APB error
      logic [2:0] hostid;       // Bit 0 picks the host port
   } umi_cmd_t;

   // Request and response packet, 224 bits
   typedef struct packed {
      umi_cmd_t cmd;
      addr_t    dstaddr;
      addr_t    srcaddr;
      data_t    data;
   } umi_pkt_t;

endpackage

//--- rtl/umi_apb_top.sv
`timescale 1ns/1ps
//##########################################################################
// Register subsystem top with two UMI host ports
// Arbiter, UMI to APB bridge and APB register file on one clock
//##########################################################################

module umi_apb_top import umi_apb_pkg::*; (
   input  logic     clk,                // Core clock
   input  logic     nreset,             // Async active low reset
   // Host 0
   input  umi_pkt_t h0_req,
   input  logic     h0_req_valid,
   output logic     h0_req_ready,
   output umi_pkt_t h0_resp,
   output logic     h0_resp_valid,
   input  logic     h0_resp_ready,
   // Host 1
   input  umi_pkt_t h1_req,
   input  logic     h1_req_valid,
   output logic     h1_req_ready,
   output umi_pkt_t h1_resp,
   output logic     h1_resp_valid,
   input  logic     h1_resp_ready
);

   umi_pkt_t   bridge_req;              // Arbiter to bridge
   logic       bridge_req_valid;
   logic       bridge_req_ready;
   umi_pkt_t   bridge_resp;             // Bridge to arbiter
   logic       bridge_resp_valid;
   logic       bridge_resp_ready;

   logic       psel;                    // APB bus
   logic       penable;
   logic       pwrite;
   paddr_t     paddr;
   data_t      pwdata;
   strb_t      pstrb;
   logic       pready;
   logic       pslverr;
   data_t      prdata;

   umi_host_arbiter arbiter_i (.*);

   umi2apb bridge_i (
      .clk        (clk),
      .nreset     (nreset),
      .req        (bridge_req),
      .req_valid  (bridge_req_valid),
      .req_ready  (bridge_req_ready),
      .resp       (bridge_resp),
      .resp_valid (bridge_resp_valid),
      .resp_ready (bridge_resp_ready),
      .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
      .pprot      (),                   // Register file has no protection input
      .pready, .pslverr, .prdata
   );

   apb_regfile regfile_i (
      .clk, .nreset, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
      .pready, .prdata, .pslverr
   );

endmodule

//--- rtl/umi_host_arbiter.sv
`timescale 1ns/1ps
//##########################################################################
// Two-host round-robin arbiter in front of the UMI to APB bridge
// Requests are muxed onto the bridge and responses steered back by hostid
//##########################################################################

module umi_host_arbiter import umi_apb_pkg::*; (
   input  logic     clk,                // Core clock
   input  logic     nreset,             // Async active low reset
   // Host 0 request
   input  umi_pkt_t h0_req,
   input  logic     h0_req_valid,
   output logic     h0_req_ready,
   // Host 1 request
   input  umi_pkt_t h1_req,
   input  logic     h1_req_valid,
   output logic     h1_req_ready,
   // Host 0 response
   output umi_pkt_t h0_resp,
   output logic     h0_resp_valid,
   input  logic     h0_resp_ready,
   // Host 1 response
   output umi_pkt_t h1_resp,
   output logic     h1_resp_valid,
   input  logic     h1_resp_ready,
   // Bridge side
   output umi_pkt_t bridge_req,
   output logic     bridge_req_valid,
   input  logic     bridge_req_ready,
   input  umi_pkt_t bridge_resp,
   input  logic     bridge_resp_valid,
   output logic     bridge_resp_ready
);

   logic turn;       // Host with priority, 0 after reset
   logic gnt1;       // Host 1 owns the bridge request
   logic resp_h1;    // Response goes to host 1

   //#######################################################################
   // Request side
   //#######################################################################

   // Host 1 wins on its turn or when host 0 is idle
   assign gnt1 = h1_req_valid & (turn | ~h0_req_valid);

   assign bridge_req       = gnt1 ? h1_req : h0_req;
   assign bridge_req_valid = gnt1 ? h1_req_valid : h0_req_valid;

   assign h0_req_ready = bridge_req_ready & ~gnt1;   // Only the granted host
   assign h1_req_ready = bridge_req_ready & gnt1;    // sees ready

   // Pointer moves past whoever was just served
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         turn <= 1'b0;
      end else if (bridge_req_valid && bridge_req_ready) begin
         turn <= ~gnt1;
      end
   end

   //#######################################################################
   // Response side
   //#######################################################################

   assign resp_h1 = bridge_resp.cmd.hostid[0];

   assign h0_resp = bridge_resp;                      // Shared payload
   assign h1_resp = bridge_resp;

   assign h0_resp_valid = bridge_resp_valid & ~resp_h1;
   assign h1_resp_valid = bridge_resp_valid & resp_h1;

   assign bridge_resp_ready = resp_h1 ? h1_resp_ready : h0_resp_ready;

   //#######################################################################
   // Checks
   //#######################################################################

   // A waiting host is not passed over twice in a row
   a_fair_h0 : assert property (@(posedge clk) disable iff (!nreset)
      h0_req_valid && h0_req_ready && h1_req_valid |=> !h0_req_ready);
   a_fair_h1 : assert property (@(posedge clk) disable iff (!nreset)
      h1_req_valid && h1_req_ready && h0_req_valid |=> !h1_req_ready);

endmodule

//--- test/umi_apb_tb.sv
`timescale 1ns/1ps
//##########################################################################
// Testbench for the two-host UMI to APB register subsystem
// Mixed traffic from both hosts runs against a shadow register model
// Concurrent assertions check routing, data, ordering and back-pressure
//##########################################################################

module umi_apb_tb import umi_apb_pkg::*; ();

   localparam int N_RAND  = 20;                        // Random requests per host
   localparam int N_PHASE = N_RAND + 4;                // Plus the error cases
   localparam int N_SWEEP = REG_COUNT / 2;             // Final reads per host

   logic     clk;
   logic     nreset;
   umi_pkt_t h0_req;
   logic     h0_req_valid;
   logic     h0_req_ready;
   umi_pkt_t h0_resp;
   logic     h0_resp_valid;
   logic     h0_resp_ready;
   umi_pkt_t h1_req;
   logic     h1_req_valid;
   logic     h1_req_ready;
   umi_pkt_t h1_resp;
   logic     h1_resp_valid;
   logic     h1_resp_ready;

   integer   seed = 32'h213729ca;
   umi_pkt_t req_q0 [$];                               // Pending host 0 requests
   umi_pkt_t req_q1 [$];
   data_t    shadow [REG_COUNT];                       // Expected register contents
   umi_pkt_t exp_resp;                                 // Next response due
   logic     exp_valid;
   logic     exp_host;
   logic     exp_data_chk;                             // Data only checked on reads
   logic     exp_turn;                                 // Host due a grant on contention
   int       exp_count;
   int       resp_count;
   int       wd_cycles = 0;

   umi_apb_top dut_i (.*);

   always #20 clk = ~clk;                              // 40 ns period

   //#######################################################################
   // Helpers
   //#######################################################################

   task automatic fail_run(input string msg);
      $display("%s at %0t ns", msg, $time);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic report_value(input string name, input logic [223:0] exp,
                               input logic [223:0] act);
      $display("ERR time %0t ns signal %s expected %h actual %h", $time, name, exp, act);
      $display("Finished with errors");
      $fatal(1);
   endtask

   function automatic paddr_t reg_addr(input reg_idx_t idx);
      return paddr_t'(idx) << 3;                       // 8 bytes per register
   endfunction

   function automatic umi_pkt_t make_req(input bit host, input logic [4:0] op,
                                         input logic [7:0] grp, input paddr_t pa);
      umi_pkt_t p;
      p.cmd           = umi_cmd_t'($random(seed));     // Random side fields
      p.cmd.opcode    = op;
      p.cmd.err       = ERR_OK;
      p.cmd.hostid[0] = host;                          // Upper hostid bits stay random
      p.dstaddr       = {$random(seed), grp, 8'h00, pa};
      p.srcaddr       = {$random(seed), $random(seed)};
      p.data          = {$random(seed), $random(seed)};
      return p;
   endfunction

   function automatic logic resp_ok(input umi_pkt_t got, input umi_pkt_t exp,
                                    input logic chk_data);
      return (got.cmd == exp.cmd) && (got.dstaddr == exp.dstaddr) &&
             (got.srcaddr == exp.srcaddr) && (!chk_data || got.data == exp.data);
   endfunction

   task automatic queue_req(input bit host, input umi_pkt_t p);
      if (host) req_q1.push_back(p);
      else      req_q0.push_back(p);
   endtask

   task automatic build_traffic(input bit host);
      int       pick;
      reg_idx_t idx;
      for (int i = 0; i < N_RAND; i++) begin
         pick = $random(seed) & 7;
         idx  = reg_idx_t'($random(seed));             // Even and odd indexes
         case (pick)
            0, 1, 2: queue_req(host, make_req(host, UMI_REQ_WRITE, GRP_ID, reg_addr(idx)));
            3:       queue_req(host, make_req(host, UMI_REQ_POSTED, GRP_ID, reg_addr(idx)));
            default: queue_req(host, make_req(host, UMI_REQ_READ, GRP_ID, reg_addr(idx)));
         endcase
      end
      queue_req(host, make_req(host, UMI_REQ_READ, GRP_ID, 16'h0080));    // Past the map
      queue_req(host, make_req(host, UMI_REQ_WRITE, GRP_ID, 16'h0108));
      queue_req(host, make_req(host, UMI_REQ_WRITE, 8'hA5, reg_addr(3))); // Foreign group
      queue_req(host, make_req(host, UMI_REQ_ATOMIC, GRP_ID, reg_addr(4)));
      for (int i = 0; i < N_SWEEP; i++) begin
         queue_req(host, make_req(host, UMI_REQ_READ, GRP_ID, reg_addr(reg_idx_t'(host * 8 + i))));
      end
   endtask

   // Presents n queued requests back to back, valid held until each is taken
   task automatic run_host(input bit host, input int n);
      umi_pkt_t p;
      for (int i = 0; i < n; i++) begin
         p = host ? req_q1.pop_front() : req_q0.pop_front();
         @(negedge clk);
         if (host) begin
            h1_req       = p;
            h1_req_valid = 1'b1;
         end else begin
            h0_req       = p;
            h0_req_valid = 1'b1;
         end
         do @(posedge clk);
         while (!(host ? (h1_req_valid && h1_req_ready) : (h0_req_valid && h0_req_ready)));
      end
      @(negedge clk);
      if (host) h1_req_valid = 1'b0;
      else      h0_req_valid = 1'b0;
   endtask

   task automatic drain();
      repeat (2) @(negedge clk);
      while (exp_valid) @(negedge clk);                // Last response taken
      repeat (4) @(negedge clk);
   endtask

   //#######################################################################
   // Shadow model, advanced in grant order
   //#######################################################################

   always @(posedge clk or negedge nreset) begin
      umi_pkt_t r;
      umi_pkt_t e;
      logic     in_map;
      reg_idx_t idx;
      if (!nreset) begin
         for (int i = 0; i < REG_COUNT; i++) shadow[i] = '0;
         exp_valid  <= 1'b0;
         exp_turn   <= 1'b0;
         exp_count  <= 0;
         resp_count <= 0;
      end else begin
         if ((h0_resp_valid && h0_resp_ready) || (h1_resp_valid && h1_resp_ready)) begin
            exp_valid  <= 1'b0;
            resp_count <= resp_count + 1;
         end
         if ((h0_req_valid && h0_req_ready) || (h1_req_valid && h1_req_ready)) begin
            r        = h1_req_ready ? h1_req : h0_req;
            exp_turn <= ~h1_req_ready;                 // Priority passes to the other host
            in_map   = r.dstaddr[PADDR_W-1:0] < paddr_t'(REG_COUNT * 8);
            idx      = r.dstaddr[6:3];
            if (r.dstaddr[GRP_OFFSET +: GRP_AW] == GRP_ID &&
                r.cmd.opcode inside {UMI_REQ_READ, UMI_REQ_WRITE, UMI_REQ_POSTED}) begin
               if (r.cmd.opcode != UMI_REQ_READ && in_map) shadow[idx] = r.data;
               if (r.cmd.opcode != UMI_REQ_POSTED) begin
                  e            = r;
                  e.cmd.opcode = (r.cmd.opcode == UMI_REQ_READ) ? UMI_RESP_READ : UMI_RESP_WRITE;
                  e.cmd.err    = in_map ? ERR_OK : ERR_SLV;
                  e.dstaddr    = r.srcaddr;            // Addresses swap
                  e.srcaddr    = r.dstaddr;
                  e.data       = (r.cmd.opcode == UMI_REQ_READ && in_map) ? shadow[idx] : '0;
                  exp_resp     <= e;
                  exp_data_chk <= (r.cmd.opcode == UMI_REQ_READ);
                  exp_host     <= r.cmd.hostid[0];
                  exp_valid    <= 1'b1;
                  exp_count    <= exp_count + 1;
               end
            end
         end
      end
   end

   //#######################################################################
   // Checks
   //#######################################################################

   a_h0_route : assert property (@(posedge clk) disable iff (!nreset)
      h0_resp_valid |-> exp_valid && !exp_host)
      else fail_run("Response on host 0 with no pending request for host 0");
   a_h1_route : assert property (@(posedge clk) disable iff (!nreset)
      h1_resp_valid |-> exp_valid && exp_host)
      else fail_run("Response on host 1 with no pending request for host 1");
   a_h0_resp : assert property (@(posedge clk) disable iff (!nreset)
      h0_resp_valid |-> resp_ok(h0_resp, exp_resp, exp_data_chk))
      else report_value("h0_resp", $sampled(exp_resp), $sampled(h0_resp));
   a_h1_resp : assert property (@(posedge clk) disable iff (!nreset)
      h1_resp_valid |-> resp_ok(h1_resp, exp_resp, exp_data_chk))
      else report_value("h1_resp", $sampled(exp_resp), $sampled(h1_resp));
   a_h0_hold : assert property (@(posedge clk) disable iff (!nreset)
      h0_resp_valid && !h0_resp_ready |=> h0_resp_valid && $stable(h0_resp))
      else fail_run("Host 0 response dropped or changed while ready was low");
   a_h1_hold : assert property (@(posedge clk) disable iff (!nreset)
      h1_resp_valid && !h1_resp_ready |=> h1_resp_valid && $stable(h1_resp))
      else fail_run("Host 1 response dropped or changed while ready was low");
   // Grant under contention follows the round-robin turn
   a_alternate : assert property (@(posedge clk) disable iff (!nreset)
      h0_req_valid && h1_req_valid && (h0_req_ready || h1_req_ready) |->
      h1_req_ready == exp_turn)
      else report_value("h1_req_ready", 224'($sampled(exp_turn)), 224'($sampled(h1_req_ready)));

   //#######################################################################
   // Stimulus
   //#######################################################################

   always @(negedge clk) begin
      h0_resp_ready = ($random(seed) & 3) != 0;        // Random back-pressure
      h1_resp_ready = ($random(seed) & 3) != 0;
   end

   initial begin
      wait (wd_cycles != 0);
      repeat (wd_cycles) @(posedge clk);
      fail_run("Timeout, traffic did not complete in the allowed time");
   end

   initial begin
      clk           = 1'b0;
      nreset        = 1'b0;
      h0_req        = '0;
      h0_req_valid  = 1'b0;
      h0_resp_ready = 1'b1;
      h1_req        = '0;
      h1_req_valid  = 1'b0;
      h1_resp_ready = 1'b1;
      build_traffic(1'b0);
      build_traffic(1'b1);
      wd_cycles = 2 * (N_PHASE + N_SWEEP) * 200 + 4;
      repeat (4) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      fork
         run_host(1'b0, N_PHASE);
         run_host(1'b1, N_PHASE);
      join
      drain();
      fork                                             // Read back every register
         run_host(1'b0, N_SWEEP);
         run_host(1'b1, N_SWEEP);
      join
      drain();
      if (exp_count == resp_count && !exp_valid) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         fail_run("Fewer responses than requests that need one");
      end
   end

endmodule
